//--- liftScheduler.f
+incdir+src
src/liftPkg.sv
src/wbBusPkg.sv
src/requestIntake.sv
src/insertPlanner.sv
src/requestQueue.sv
src/carDispatcher.sv
src/liftScheduler.sv
tb/liftSchedulerTb.sv

//--- tb/liftSchedulerTb.sv
`default_nettype none
`timescale 1ns/1ps

`include "liftScheduler_config.svh"

module liftSchedulerTb
    import liftPkg::*, wbBusPkg::*;
();

    localparam int ClockPeriod = 40;
    localparam int PlaceRequests = 12;
    localparam int ServiceRequests = 10;
    localparam int BusTimeout = 20;                 // cycles to wait for ack or err
    // worst case per request: three floor steps each way plus two door openings
    localparam int ServiceCycles = 6 * `TRAVEL_CYCLES + 2 * `DOOR_CYCLES + 8;
    localparam int RequestTotal = `QUEUE_DEPTH + 1 + ServiceRequests;
    localparam int MarginCycles = 4000;             // bus traffic of the placement checks
    localparam int WatchdogNs = (RequestTotal * ServiceCycles + MarginCycles) * ClockPeriod;

    logic       clk;
    logic       clear;
    logic       cyc;
    logic       stb;
    logic       we;
    wbAddrT     adr;
    wbDataT     datIn;
    wbDataT     datOut;
    logic       ack;
    logic       err;
    floorT      carFloor;
    logic       doorOpen;
    logic       served;
    queueEntryT servedEntry;

    integer     seed;
    queueEntryT modelQ [$];         // expected queue order, head first
    queueEntryT inService;          // entry the car is carrying
    logic       popPending = 1'b0;
    logic       prevDoor = 1'b0;
    floorT      prevFloor = '0;
    int         doorCount = 0;
    int         servedCount = 0;
    int         acceptedCount = 0;

    liftScheduler dut (
        .clk(clk), .clear(clear), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datIn(datIn),
        .datOut(datOut), .ack(ack), .err(err), .carFloor(carFloor), .doorOpen(doorOpen),
        .served(served), .servedEntry(servedEntry)
    );

    initial begin
        clk = 1'b0;
        forever #(ClockPeriod / 2) clk = ~clk;
    end

    initial begin
        #(WatchdogNs);
        $display("run timed out before all requests were served");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            reportFailure($sformatf("error %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    // entry layout from the register map, local when origin equals destination
    function automatic queueEntryT buildEntry(objTypeT objType, floorT origin, floorT dest);
        return {(origin == dest) ? 1'b1 : 1'b0, objType, origin, dest};
    endfunction

    function automatic void modelInsert(queueEntryT entry);
        int pos;
        queueEntryT slot;
        pos = modelQ.size();
        for (int i = modelQ.size() - 1; i >= 0; i--) begin
            slot = modelQ[i];
            if (slot[5:4] < entry[5:4]) begin
                pos = i;    // first slot of lower urgency wins
            end
        end
        modelQ.insert(pos, entry);
    endfunction

    task automatic busCycle(input logic write, input wbAddrT addr, input wbDataT wdata,
                            output wbDataT rdata, output logic gotErr);
        int waited;
        @(posedge clk);
        #2;
        cyc = 1'b1;
        stb = 1'b1;
        we = write;
        adr = addr;
        datIn = wdata;
        waited = 0;
        @(negedge clk);
        while (!ack && !err && (waited < BusTimeout)) begin
            waited++;
            @(negedge clk);
        end
        if (!ack && !err) begin
            reportFailure("bus cycle ended without ack or err");
        end else begin
            rdata = datOut;
            gotErr = err;
            @(posedge clk);
            #2;
            cyc = 1'b0;     // master drops the strobe after the answer
            stb = 1'b0;
            we = 1'b0;
        end
    endtask

    task automatic wbWrite(input wbAddrT addr, input wbDataT data, output logic gotErr);
        wbDataT unused;
        busCycle(1'b1, addr, data, unused, gotErr);
    endtask

    task automatic wbRead(input wbAddrT addr, output wbDataT data, output logic gotErr);
        busCycle(1'b0, addr, '0, data, gotErr);
    endtask

    task automatic submitRequest(input logic urgent, input logic expectErr);
        objTypeT objType;
        floorT   origin;
        floorT   dest;
        logic    gotErr;
        objType = objTypeT'($random(seed));
        if (urgent) begin
            objType = 2'd3;
        end
        origin = floorT'($random(seed));
        dest = floorT'($random(seed));
        wbWrite(REQ_ADDR, {2'b00, objType, origin, dest}, gotErr);
        checkValue("request response", expectErr, gotErr);
        if (!gotErr) begin
            modelInsert(buildEntry(objType, origin, dest));
            acceptedCount++;
        end
    endtask

    task automatic checkQueueContents(input string label);
        wbDataT      data;
        logic        gotErr;
        logic [31:0] expected;
        expected = modelQ.size();
        if (modelQ.size() == `QUEUE_DEPTH) begin
            expected[STATUS_FULL_BIT] = 1'b1;
        end
        wbRead(STATUS_ADDR, data, gotErr);
        checkValue({label, " status response"}, 0, gotErr);
        checkValue({label, " status"}, expected, data);
        for (int i = 0; i < `QUEUE_DEPTH; i++) begin
            expected = (i < modelQ.size()) ? 32'(modelQ[i]) : 32'd0;
            wbRead(wbAddrT'(PEEK_BASE + i), data, gotErr);
            checkValue($sformatf("%s peek slot %0d", label, i), expected, data);
        end
    endtask

    // car and service monitor, sampled mid cycle
    initial begin
        int delta;
        @(negedge clear);
        forever begin
            @(negedge clk);
            if (popPending) begin
                // the pop took effect at the previous rising edge
                if (modelQ.size() == 0) begin
                    reportFailure("queue handed out an entry the model does not hold");
                end else begin
                    inService = modelQ.pop_front();
                end
            end
            popPending = dut.popAck;
            delta = int'(carFloor) - int'(prevFloor);
            if ((delta > 1) || (delta < -1)) begin
                reportFailure("car moved more than one floor at once");
            end
            if (doorOpen && !prevDoor) begin
                doorCount++;
                checkValue("door floor", (doorCount == 1) ? inService[3:2] : inService[1:0],
                           carFloor);
            end
            if (served) begin
                checkValue("served entry", inService, servedEntry);
                checkValue("door openings", inService[6] ? 1 : 2, doorCount);
                checkValue("served floor", inService[1:0], carFloor);
                doorCount = 0;
                servedCount++;
            end
            prevFloor = carFloor;
            prevDoor = doorOpen;
        end
    end

    initial begin
        wbDataT data;
        logic   gotErr;
        int     gap;
        seed = 32'h337b;
        clear = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        datIn = '0;
        repeat (4) @(posedge clk);
        #2;
        clear = 1'b0;

        wbRead(CTRL_ADDR, data, gotErr);
        checkValue("reset ctrl", 0, data);
        checkValue("reset car floor", 0, carFloor);
        checkQueueContents("reset");

        // run is 0, so the queue only grows
        repeat (PlaceRequests) begin
            submitRequest(1'b0, 1'b0);
            checkQueueContents("placement");
        end

        while (modelQ.size() < `QUEUE_DEPTH) begin
            submitRequest(1'b0, 1'b0);
        end
        submitRequest(1'b0, 1'b1);      // one past full
        checkQueueContents("overflow");

        wbWrite(CTRL_ADDR, 8'h01, gotErr);
        checkValue("ctrl write response", 0, gotErr);
        wbRead(CTRL_ADDR, data, gotErr);
        checkValue("ctrl readback", 1, data);

        // new requests while the car works, every other one urgent
        for (int k = 0; k < ServiceRequests; k++) begin
            gap = $random(seed) & 32'h3f;
            repeat (gap) @(posedge clk);
            while (modelQ.size() >= `QUEUE_DEPTH) begin
                @(negedge clk);
            end
            submitRequest(k[0], 1'b0);
        end

        while (servedCount < acceptedCount) begin
            @(negedge clk);
        end
        repeat (4) @(posedge clk);
        checkQueueContents("drained");
        checkValue("door after drain", 0, doorOpen);

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/liftScheduler.sv
`default_nettype none
`timescale 1ns/1ps

`include "liftScheduler_config.svh"

module liftScheduler
    import liftPkg::*, wbBusPkg::*;
(
    input  logic       clk,
    input  logic       clear,
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  wbAddrT     adr,
    input  wbDataT     datIn,
    output wbDataT     datOut,
    output logic       ack,
    output logic       err,
    output floorT      carFloor,
    output logic       doorOpen,
    output logic       served,
    output queueEntryT servedEntry
);

    logic                       reqValid;
    logic                       placeDone;
    logic                       placeReject;
    logic                       insertEn;
    logic                       popReq;
    logic                       popAck;
    logic                       run;
    queueEntryT                 reqEntry;
    queueEntryT                 insertEntry;
    queueEntryT                 headEntry;
    queueEntryT                 peekEntry;
    slotT                       insertSlot;
    slotT                       peekSlot;
    countT                      count;
    objTypeT [`QUEUE_DEPTH-1:0] slotTypes;
    logic [`QUEUE_DEPTH-1:0]    slotUsed;

    requestIntake intake (
        .clk(clk), .clear(clear), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datIn(datIn),
        .placeDone(placeDone), .placeReject(placeReject), .count(count),
        .peekEntry(peekEntry), .datOut(datOut), .ack(ack), .err(err),
        .reqValid(reqValid), .reqEntry(reqEntry), .peekSlot(peekSlot), .run(run)
    );

    insertPlanner planner (
        .clk(clk), .clear(clear), .reqValid(reqValid), .reqEntry(reqEntry),
        .slotTypes(slotTypes), .slotUsed(slotUsed), .count(count),
        .placeDone(placeDone), .placeReject(placeReject), .insertEn(insertEn),
        .insertSlot(insertSlot), .insertEntry(insertEntry)
    );

    requestQueue queue (
        .clk(clk), .clear(clear), .insertEn(insertEn), .insertSlot(insertSlot),
        .insertEntry(insertEntry), .popReq(popReq), .peekSlot(peekSlot),
        .popAck(popAck), .headEntry(headEntry), .count(count),
        .slotTypes(slotTypes), .slotUsed(slotUsed), .peekEntry(peekEntry)
    );

    carDispatcher dispatcher (
        .clk(clk), .clear(clear), .run(run), .headEntry(headEntry), .count(count),
        .popAck(popAck), .popReq(popReq), .carFloor(carFloor), .doorOpen(doorOpen),
        .served(served), .servedEntry(servedEntry)
    );

endmodule

`default_nettype wire

//--- src/carDispatcher.sv
`default_nettype none
`timescale 1ns/1ps

`include "liftScheduler_config.svh"

module carDispatcher
    import liftPkg::*;
(
    input  logic       clk,
    input  logic       clear,
    input  logic       run,
    input  queueEntryT headEntry,
    input  countT      count,
    input  logic       popAck,
    output logic       popReq,
    output floorT      carFloor,
    output logic       doorOpen,
    output logic       served,
    output queueEntryT servedEntry
);

    localparam int TimerMax = (`TRAVEL_CYCLES > `DOOR_CYCLES) ? `TRAVEL_CYCLES : `DOOR_CYCLES;
    localparam int TimerWidth = $clog2(TimerMax + 1);

    dispatchStateT         state;
    queueEntryT            curEntry;
    logic [TimerWidth-1:0] timer;
    floorT                 target;
    logic                  atTarget;
    logic                  stepDone;
    logic                  doorDone;

    assign target = (state == toDest) ? entryDest(curEntry) : entryOrigin(curEntry);
    assign atTarget = (carFloor == target);
    assign stepDone = (timer == TimerWidth'(`TRAVEL_CYCLES - 1));
    assign doorDone = (timer == TimerWidth'(`DOOR_CYCLES - 1));

    assign popReq = (state == pop);     // held until the queue acks
    assign doorOpen = (state == doorOrigin) || (state == doorDest);
    assign servedEntry = curEntry;

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            state <= idle;
            carFloor <= '0;
            timer <= '0;
            served <= 1'b0;
        end else begin
            served <= 1'b0;
            case (state)
                idle: begin
                    if (run && (count != '0)) begin
                        state <= pop;
                    end
                end
                pop: begin
                    if (popAck) begin
                        state <= toOrigin;
                        timer <= '0;
                    end
                end
                toOrigin, toDest: begin
                    if (atTarget) begin
                        state <= (state == toOrigin) ? doorOrigin : doorDest;
                        timer <= '0;
                    end else if (stepDone) begin
                        // one floor per step toward the target
                        carFloor <= (target > carFloor) ? carFloor + 1'b1 : carFloor - 1'b1;
                        timer <= '0;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                doorOrigin: begin
                    if (doorDone) begin
                        timer <= '0;
                        if (entryLocal(curEntry)) begin
                            served <= 1'b1;     // local entry needs one opening only
                            state <= idle;
                        end else begin
                            state <= toDest;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                doorDest: begin
                    if (doorDone) begin
                        timer <= '0;
                        served <= 1'b1;
                        state <= idle;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == pop) && popAck) begin
            curEntry <= headEntry;  // head before the shift
        end
    end

    assert property (@(posedge clk) disable iff (clear)
        (int'(carFloor) - int'($past(carFloor))) inside {-1, 0, 1})
        else $error("car moved more than one floor in a step");

endmodule

`default_nettype wire

//--- src/requestQueue.sv
`default_nettype none
`timescale 1ns/1ps

`include "liftScheduler_config.svh"

module requestQueue
    import liftPkg::*;
(
    input  logic                        clk,
    input  logic                        clear,
    input  logic                        insertEn,
    input  slotT                        insertSlot,
    input  queueEntryT                  insertEntry,
    input  logic                        popReq,
    input  slotT                        peekSlot,
    output logic                        popAck,
    output queueEntryT                  headEntry,
    output countT                       count,
    output objTypeT [`QUEUE_DEPTH-1:0]  slotTypes,
    output logic [`QUEUE_DEPTH-1:0]     slotUsed,
    output queueEntryT                  peekEntry
);

    queueEntryT slots [`QUEUE_DEPTH];
    slotT       peekSlotReg;

    // pop only goes through in a cycle without an insert
    assign popAck = popReq & ~insertEn & (count != '0);

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            for (int i = 0; i < `QUEUE_DEPTH; i++) begin
                slots[i] <= '0;     // zero marks an empty slot
            end
            count <= '0;
        end else if (insertEn) begin
            // the chosen slot and everything behind it move back by one
            for (int i = 1; i < `QUEUE_DEPTH; i++) begin
                if (slotT'(i) > insertSlot) begin
                    slots[i] <= slots[i-1];
                end
            end
            slots[insertSlot] <= insertEntry;
            count <= count + 1'b1;
        end else if (popAck) begin
            for (int i = 0; i < `QUEUE_DEPTH - 1; i++) begin
                slots[i] <= slots[i+1];
            end
            slots[`QUEUE_DEPTH-1] <= '0;  // tail freed
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        peekSlotReg <= peekSlot;
    end

    assign headEntry = slots[0];
    assign peekEntry = slots[peekSlotReg];    // one clock after the slot number

    // snapshot for the planner
    always_comb begin
        for (int i = 0; i < `QUEUE_DEPTH; i++) begin
            slotUsed[i] = (slots[i] != '0);
            slotTypes[i] = entryType(slots[i]);
        end
    end

    // filled slots form a block from slot 0 that matches the count
    assert property (@(posedge clk) disable iff (clear)
        slotUsed == ({`QUEUE_DEPTH{1'b1}} >> (`QUEUE_DEPTH - count)))
        else $error("queue occupancy has a gap");

endmodule

`default_nettype wire

//--- src/insertPlanner.sv
`default_nettype none
`timescale 1ns/1ps

`include "liftScheduler_config.svh"

module insertPlanner
    import liftPkg::*;
(
    input  logic                        clk,
    input  logic                        clear,
    input  logic                        reqValid,
    input  queueEntryT                  reqEntry,
    input  objTypeT [`QUEUE_DEPTH-1:0]  slotTypes,
    input  logic [`QUEUE_DEPTH-1:0]     slotUsed,
    input  countT                       count,
    output logic                        placeDone,
    output logic                        placeReject,
    output logic                        insertEn,
    output slotT                        insertSlot,
    output queueEntryT                  insertEntry
);

    queueEntryT holdEntry;
    logic       holdValid;
    logic       full;
    logic       found;
    objTypeT    newType;
    slotT       fitSlot;

    assign full = (count == countT'(`QUEUE_DEPTH));
    assign newType = entryType(holdEntry);

    // first occupied slot with a strictly lower type
    always_comb begin
        found = 1'b0;
        fitSlot = '0;
        for (int i = `QUEUE_DEPTH - 1; i >= 0; i--) begin
            if (slotUsed[i] && (slotTypes[i] < newType)) begin
                found = 1'b1;
                fitSlot = slotT'(i);
            end
        end
    end

    // insert happens during the holding cycle so the snapshot cannot go stale
    assign insertEn = holdValid & ~full;
    assign insertSlot = found ? fitSlot : slotT'(count);   // else append at the tail
    assign insertEntry = holdEntry;

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            holdValid <= 1'b0;
            placeDone <= 1'b0;
            placeReject <= 1'b0;
        end else begin
            placeDone <= holdValid;             // answer one cycle after taking
            placeReject <= holdValid & full;
            holdValid <= reqValid & ~holdValid;
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid && !holdValid) begin
            holdEntry <= reqEntry;
        end
    end

    assert property (@(posedge clk) disable iff (clear)
        !(insertEn && (&slotUsed)))
        else $error("insert into a full queue");

endmodule

`default_nettype wire

//--- src/requestIntake.sv
`default_nettype none
`timescale 1ns/1ps

`include "liftScheduler_config.svh"

module requestIntake
    import liftPkg::*, wbBusPkg::*;
(
    input  logic       clk,
    input  logic       clear,
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  wbAddrT     adr,
    input  wbDataT     datIn,
    input  logic       placeDone,
    input  logic       placeReject,
    input  countT      count,
    input  queueEntryT peekEntry,
    output wbDataT     datOut,
    output logic       ack,
    output logic       err,
    output logic       reqValid,
    output queueEntryT reqEntry,
    output slotT       peekSlot,
    output logic       run
);

    logic   access;
    logic   start;
    logic   busy;       // read or request write in flight
    logic   readPend;
    logic   ackReg;
    logic   full;
    wbAddrT readAdr;
    wbDataT readData;

    assign access = cyc & stb;
    // the cycle that sees ack or err still has the old stb
    assign start = access & ~busy & ~ack & ~err;
    assign full = (count == countT'(`QUEUE_DEPTH));
    assign peekSlot = slotT'(adr - PEEK_BASE);  // queue registers it

    // request writes end straight from the planner answer
    assign ack = ackReg | (placeDone & ~placeReject);
    assign err = placeDone & placeReject;

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            busy <= 1'b0;
            readPend <= 1'b0;
            ackReg <= 1'b0;
            reqValid <= 1'b0;
            run <= 1'b0;
        end else begin
            ackReg <= 1'b0;
            reqValid <= 1'b0;
            if (readPend) begin
                readPend <= 1'b0;   // peek data is ready now
                busy <= 1'b0;
                ackReg <= 1'b1;
            end else if (busy && placeDone) begin
                busy <= 1'b0;
            end else if (start) begin
                if (!we) begin
                    readPend <= 1'b1;
                    busy <= 1'b1;
                end else if (adr == REQ_ADDR) begin
                    reqValid <= 1'b1;
                    busy <= 1'b1;
                end else begin
                    ackReg <= 1'b1;     // other writes finish in one cycle
                    if (adr == CTRL_ADDR) begin
                        run <= datIn[CTRL_RUN_BIT];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            readAdr <= adr;
            reqEntry <= makeEntry(datIn[REQ_TYPE_LSB +: $bits(objTypeT)],
                                  datIn[REQ_ORIGIN_LSB +: $bits(floorT)],
                                  datIn[REQ_DEST_LSB +: $bits(floorT)]);
        end
        if (readPend) begin
            datOut <= readData;
        end
    end

    always_comb begin
        readData = '0;      // unmapped reads return zero
        if (readAdr >= PEEK_BASE) begin
            readData = wbDataT'(peekEntry);
        end else if (readAdr == STATUS_ADDR) begin
            readData[STATUS_FULL_BIT] = full;
            readData[$bits(countT)-1:0] = count;
        end else if (readAdr == CTRL_ADDR) begin
            readData[CTRL_RUN_BIT] = run;
        end
    end

    assert property (@(posedge clk) disable iff (clear) !(ack && err))
        else $error("ack and err asserted together");

    assert property (@(posedge clk) disable iff (clear) ack |-> stb)
        else $error("ack outside a strobe");

endmodule

`default_nettype wire

//--- src/wbBusPkg.sv
`default_nettype none

`include "liftScheduler_config.svh"

package wbBusPkg;

    typedef logic [`WB_ADDR_WIDTH-1:0] wbAddrT;
    typedef logic [`WB_DATA_WIDTH-1:0] wbDataT;

    // register map
    localparam wbAddrT REQ_ADDR    = 5'd0;     // write submits a request
    localparam wbAddrT STATUS_ADDR = 5'd0;     // read gives full and count
    localparam wbAddrT CTRL_ADDR   = 5'd1;     // run bit
    localparam wbAddrT PEEK_BASE   = 5'd16;    // 16..31 map to queue slots 0..15

    // bit positions inside the data word
    localparam int REQ_TYPE_LSB    = 4;
    localparam int REQ_ORIGIN_LSB  = 2;
    localparam int REQ_DEST_LSB    = 0;
    localparam int STATUS_FULL_BIT = 7;
    localparam int CTRL_RUN_BIT    = 0;

endpackage

`default_nettype wire

//--- src/liftPkg.sv
`default_nettype none

`include "liftScheduler_config.svh"

package liftPkg;

    typedef logic [$clog2(`FLOOR_COUNT)-1:0] floorT;
    typedef logic [1:0] objTypeT;                       // higher is more urgent
    typedef logic [6:0] queueEntryT;                    // {local, type, origin, dest}
    typedef logic [$clog2(`QUEUE_DEPTH)-1:0] slotT;
    typedef logic [$clog2(`QUEUE_DEPTH):0] countT;      // 0 to QUEUE_DEPTH

    typedef enum logic [2:0] {
        idle,
        pop,
        toOrigin,
        doorOrigin,
        toDest,
        doorDest
    } dispatchStateT;

    // local flag keeps every valid entry nonzero
    function automatic queueEntryT makeEntry(objTypeT objType, floorT origin, floorT dest);
        return {origin == dest, objType, origin, dest};
    endfunction

    function automatic logic entryLocal(queueEntryT entry);
        return entry[6];
    endfunction

    function automatic objTypeT entryType(queueEntryT entry);
        return entry[5:4];
    endfunction

    function automatic floorT entryOrigin(queueEntryT entry);
        return entry[3:2];
    endfunction

    function automatic floorT entryDest(queueEntryT entry);
        return entry[1:0];
    endfunction

endpackage

`default_nettype wire

//--- src/liftScheduler_config.svh
`ifndef LIFT_SCHEDULER_CONFIG_SVH
`define LIFT_SCHEDULER_CONFIG_SVH

// queue and building size
`define QUEUE_DEPTH 16
`define FLOOR_COUNT 4

// car timing in clocks
`define TRAVEL_CYCLES 4     // one floor step
`define DOOR_CYCLES 3       // door held open

// wishbone port widths
`define WB_ADDR_WIDTH 5
`define WB_DATA_WIDTH 8

`endif
